/* src/legPkg.sv */
`default_nettype none

package legPkg;

	localparam int instrWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int shamtWidth = 6;
	localparam int aluOpWidth = 3;

	// Hardwired zero register
	localparam logic [regAddrWidth-1:0] zeroReg = 5'd31;

	localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
	localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
	localparam logic [aluOpWidth-1:0] aluOrr = 3'd3;
	localparam logic [aluOpWidth-1:0] aluEor = 3'd4;
	localparam logic [aluOpWidth-1:0] aluEnor = 3'd5;

	// R and D format, 11 bits
	localparam logic [10:0] opAdd = 11'b00101000000;
	localparam logic [10:0] opAnd = 11'b00101000010;
	localparam logic [10:0] opEor = 11'b00101000100;
	localparam logic [10:0] opEnor = 11'b00101000101;
	localparam logic [10:0] opLsl = 11'b00101000110;
	localparam logic [10:0] opLsr = 11'b00101000111;
	localparam logic [10:0] opOrr = 11'b00101001000;
	localparam logic [10:0] opSub = 11'b00101001001;
	localparam logic [10:0] opLdur = 11'b11010000000;
	localparam logic [10:0] opStur = 11'b11010000001;

	// I format, 10 bits
	localparam logic [9:0] opAddi = 10'b1000100000;
	localparam logic [9:0] opAndi = 10'b1000100010;
	localparam logic [9:0] opEori = 10'b1000100100;
	localparam logic [9:0] opEnori = 10'b1000100101;
	localparam logic [9:0] opOrri = 10'b1000100110;
	localparam logic [9:0] opSubi = 10'b1000100111;

	// MOVZ, top 9 bits; the two below are hw
	localparam logic [8:0] opMovz = 9'b110010101;

	typedef struct packed {
		logic [10:0] opcode;
		logic [regAddrWidth-1:0] rm;
		logic [shamtWidth-1:0] shamt;
		logic [regAddrWidth-1:0] rn;
		logic [regAddrWidth-1:0] rd;
	} rFormat;

	typedef struct packed {
		logic [9:0] opcode;
		logic [11:0] imm;
		logic [regAddrWidth-1:0] rn;
		logic [regAddrWidth-1:0] rd;
	} iFormat;

	typedef struct packed {
		logic [10:0] opcode;
		logic [8:0] offset;
		logic [1:0] op2;
		logic [regAddrWidth-1:0] rn;
		logic [regAddrWidth-1:0] rt;
	} dFormat;

	typedef union packed {
		rFormat rView;
		iFormat iView;
		dFormat dView;
	} instrWord;

endpackage

`default_nettype wire

/* src/fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
	input  logic clk,
	input  logic reset,
	input  legPkg::instrWord instr,
	output logic [63:0] iaddr,
	output legPkg::instrWord decodeInstr
);
	import legPkg::*;

	// No branches, so the PC only steps one word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			iaddr <= '0;
		end else begin
			iaddr <= iaddr + 64'(instrWidth / 8);
		end
	end

	// All-zero word decodes as NOP
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			decodeInstr <= '0;
		end else begin
			decodeInstr <= instr;
		end
	end

endmodule

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input  legPkg::instrWord instr,
	output logic [legPkg::regAddrWidth-1:0] readRegA,
	output logic [legPkg::regAddrWidth-1:0] readRegB,
	output logic [legPkg::regAddrWidth-1:0] destReg,
	output logic [63:0] immediate,
	output logic [legPkg::shamtWidth-1:0] shamt,
	output logic [legPkg::aluOpWidth-1:0] aluOp,
	output logic useImm,
	output logic shiftLeft,
	output logic shiftRight,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg
);
	import legPkg::*;

	logic rValid;
	logic [aluOpWidth-1:0] rAluOp;
	logic iValid;
	logic [aluOpWidth-1:0] iAluOp;
	logic isLsl;
	logic isLsr;
	logic isLdur;
	logic isStur;
	logic isMovz;
	logic [15:0] movImm;
	logic [1:0] movHw;

	// Register-register ops
	always_comb begin
		rValid = 1'b1;
		rAluOp = aluAdd;
		case (instr.rView.opcode)
			opAdd: rAluOp = aluAdd;
			opSub: rAluOp = aluSub;
			opAnd: rAluOp = aluAnd;
			opOrr: rAluOp = aluOrr;
			opEor: rAluOp = aluEor;
			opEnor: rAluOp = aluEnor;
			default: rValid = 1'b0;
		endcase
	end

	// Immediate ops
	always_comb begin
		iValid = 1'b1;
		iAluOp = aluAdd;
		case (instr.iView.opcode)
			opAddi: iAluOp = aluAdd;
			opSubi: iAluOp = aluSub;
			opAndi: iAluOp = aluAnd;
			opOrri: iAluOp = aluOrr;
			opEori: iAluOp = aluEor;
			opEnori: iAluOp = aluEnor;
			default: iValid = 1'b0;
		endcase
	end

	assign isLsl = instr.rView.opcode == opLsl;
	assign isLsr = instr.rView.opcode == opLsr;
	assign isLdur = instr.dView.opcode == opLdur;
	assign isStur = instr.dView.opcode == opStur;
	assign isMovz = instr.rView.opcode[10:2] == opMovz;

	// MOVZ fields overlay the R-format positions
	assign movHw = instr.rView.opcode[1:0];
	assign movImm = {instr.rView.rm, instr.rView.shamt, instr.rView.rn};

	always_comb begin
		readRegA = instr.rView.rn;
		readRegB = instr.rView.rm;
		destReg = instr.rView.rd;
		shamt = instr.rView.shamt;
		immediate = '0;
		aluOp = aluAdd;
		useImm = 1'b0;
		shiftLeft = isLsl;
		shiftRight = isLsr;
		regWrite = rValid | iValid | isLsl | isLsr | isLdur | isMovz;
		memWrite = isStur;
		memToReg = isLdur;
		if (rValid) begin
			aluOp = rAluOp;
		end else if (iValid) begin
			aluOp = iAluOp;
			useImm = 1'b1;
			immediate = 64'(instr.iView.imm);
		end else if (isLdur || isStur) begin
			// Address is base plus unsigned byte offset
			useImm = 1'b1;
			immediate = 64'(instr.dView.offset);
			readRegB = instr.dView.rt;
		end else if (isMovz) begin
			useImm = 1'b1;
			readRegA = zeroReg;
			immediate = 64'(movImm) << {movHw, 4'b0000};
		end
	end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile #(
	parameter int dataWidth = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic [legPkg::regAddrWidth-1:0] readRegA,
	input  logic [legPkg::regAddrWidth-1:0] readRegB,
	input  logic [legPkg::regAddrWidth-1:0] writeReg,
	input  logic writeEnable,
	input  logic [dataWidth-1:0] writeValue,
	output logic [dataWidth-1:0] readA,
	output logic [dataWidth-1:0] readB
);
	import legPkg::*;

	// Only registers below the zero register have storage
	logic [dataWidth-1:0] regs [0:zeroReg-1];

	// Falling-edge write lets decode see the value in the same cycle
	always_ff @(negedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < zeroReg; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeReg != zeroReg) begin
			regs[writeReg] <= writeValue;
		end
	end

	assign readA = (readRegA == zeroReg) ? '0 : regs[readRegA];
	assign readB = (readRegB == zeroReg) ? '0 : regs[readRegB];

endmodule

`default_nettype wire

/* src/executeUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module executeUnit #(
	parameter int dataWidth = 64
) (
	input  logic [dataWidth-1:0] operandA,
	input  logic [dataWidth-1:0] operandB,
	input  logic [dataWidth-1:0] immediate,
	input  logic useImm,
	input  logic [legPkg::aluOpWidth-1:0] aluOp,
	input  logic [legPkg::shamtWidth-1:0] shamt,
	input  logic shiftLeft,
	input  logic shiftRight,
	output logic [dataWidth-1:0] result
);
	import legPkg::*;

	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluOut;

	assign aluB = useImm ? immediate : operandB;

	always_comb begin
		case (aluOp)
			aluAdd: aluOut = operandA + aluB;
			aluSub: aluOut = operandA - aluB;
			aluAnd: aluOut = operandA & aluB;
			aluOrr: aluOut = operandA | aluB;
			aluEor: aluOut = operandA ^ aluB;
			aluEnor: aluOut = ~(operandA ^ aluB);
			default: aluOut = operandA + aluB;
		endcase
	end

	// Shifts take priority over the ALU, zero fill both ways
	always_comb begin
		if (shiftLeft) begin
			result = operandA << shamt;
		end else if (shiftRight) begin
			result = operandA >> shamt;
		end else begin
			result = aluOut;
		end
	end

endmodule

`default_nettype wire

/* src/legCpu.sv */
`timescale 1ns/1ns
`default_nettype none

module legCpu #(
	parameter int dataWidth = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic [legPkg::instrWidth-1:0] instr,
	output logic [63:0] iaddr,
	output logic [63:0] daddr,
	output logic [63:0] writeData,
	output logic memWrite,
	input  logic [63:0] readData
);
	import legPkg::*;

	instrWord decodeInstr;

	// Decode stage
	logic [regAddrWidth-1:0] decRegA;
	logic [regAddrWidth-1:0] decRegB;
	logic [regAddrWidth-1:0] decDest;
	logic [63:0] decImm;
	logic [shamtWidth-1:0] decShamt;
	logic [aluOpWidth-1:0] decAluOp;
	logic decUseImm;
	logic decLsl;
	logic decLsr;
	logic decRegWrite;
	logic decMemWrite;
	logic decMemToReg;
	logic [dataWidth-1:0] regA;
	logic [dataWidth-1:0] regB;

	// Decode/execute register
	logic [dataWidth-1:0] idExA;
	logic [dataWidth-1:0] idExB;
	logic [dataWidth-1:0] idExImm;
	logic [shamtWidth-1:0] idExShamt;
	logic [aluOpWidth-1:0] idExAluOp;
	logic [regAddrWidth-1:0] idExDest;
	logic idExUseImm;
	logic idExLsl;
	logic idExLsr;
	logic idExRegWrite;
	logic idExMemWrite;
	logic idExMemToReg;
	logic [dataWidth-1:0] exResult;

	// Execute/memory register
	logic [dataWidth-1:0] exMemResult;
	logic [dataWidth-1:0] exMemStore;
	logic [regAddrWidth-1:0] exMemDest;
	logic exMemRegWrite;
	logic exMemMemToReg;

	// Memory/writeback register
	logic [dataWidth-1:0] memWbResult;
	logic [dataWidth-1:0] memWbLoad;
	logic [regAddrWidth-1:0] memWbDest;
	logic memWbRegWrite;
	logic memWbMemToReg;
	logic [dataWidth-1:0] wbValue;

	fetchUnit fetch (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.iaddr(iaddr),
		.decodeInstr(decodeInstr)
	);

	instrDecoder decoder (
		.instr(decodeInstr),
		.readRegA(decRegA),
		.readRegB(decRegB),
		.destReg(decDest),
		.immediate(decImm),
		.shamt(decShamt),
		.aluOp(decAluOp),
		.useImm(decUseImm),
		.shiftLeft(decLsl),
		.shiftRight(decLsr),
		.regWrite(decRegWrite),
		.memWrite(decMemWrite),
		.memToReg(decMemToReg)
	);

	registerFile #(.dataWidth(dataWidth)) regFile (
		.clk(clk),
		.reset(reset),
		.readRegA(decRegA),
		.readRegB(decRegB),
		.writeReg(memWbDest),
		.writeEnable(memWbRegWrite),
		.writeValue(wbValue),
		.readA(regA),
		.readB(regB)
	);

	executeUnit #(.dataWidth(dataWidth)) execute (
		.operandA(idExA),
		.operandB(idExB),
		.immediate(idExImm),
		.useImm(idExUseImm),
		.aluOp(idExAluOp),
		.shamt(idExShamt),
		.shiftLeft(idExLsl),
		.shiftRight(idExLsr),
		.result(exResult)
	);

	// Pipeline control bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idExRegWrite <= 1'b0;
			idExMemWrite <= 1'b0;
			idExMemToReg <= 1'b0;
			idExLsl <= 1'b0;
			idExLsr <= 1'b0;
			exMemRegWrite <= 1'b0;
			memWrite <= 1'b0;
			exMemMemToReg <= 1'b0;
			memWbRegWrite <= 1'b0;
			memWbMemToReg <= 1'b0;
		end else begin
			idExRegWrite <= decRegWrite;
			idExMemWrite <= decMemWrite;
			idExMemToReg <= decMemToReg;
			idExLsl <= decLsl;
			idExLsr <= decLsr;
			exMemRegWrite <= idExRegWrite;
			memWrite <= idExMemWrite;
			exMemMemToReg <= idExMemToReg;
			memWbRegWrite <= exMemRegWrite;
			memWbMemToReg <= exMemMemToReg;
		end
	end

	// Pipeline payload
	always_ff @(posedge clk) begin
		idExA <= regA;
		idExB <= regB;
		idExImm <= decImm[dataWidth-1:0];
		idExShamt <= decShamt;
		idExAluOp <= decAluOp;
		idExDest <= decDest;
		idExUseImm <= decUseImm;
		exMemResult <= exResult;
		exMemStore <= idExB;
		exMemDest <= idExDest;
		memWbResult <= exMemResult;
		memWbLoad <= readData[dataWidth-1:0];
		memWbDest <= exMemDest;
	end

	assign daddr = 64'(exMemResult);
	assign writeData = 64'(exMemStore);

	assign wbValue = memWbMemToReg ? memWbLoad : memWbResult;

endmodule

`default_nettype wire

/* testbench/legCpu_props.sv */
`timescale 1ns/1ns
`default_nettype none

module legCpuProps (
	input logic clk,
	input logic reset,
	input logic [63:0] iaddr,
	input logic memWrite,
	input logic [63:0] daddr
);
	int failCount = 0;

	// First fetch after reset comes from address zero
	property firstFetch;
		@(posedge clk) $fell(reset) |-> iaddr == 64'd0;
	endproperty

	property pcStep;
		@(posedge clk) disable iff (reset) !$fell(reset) |-> iaddr == $past(iaddr) + 64'd4;
	endproperty

	property noStoreInReset;
		@(posedge clk) reset |-> !memWrite;
	endproperty

	property storeStrobeKnown;
		@(posedge clk) disable iff (reset) !$isunknown(memWrite);
	endproperty

	property storeAddrKnown;
		@(posedge clk) disable iff (reset) memWrite |-> !$isunknown(daddr);
	endproperty

	assert property (firstFetch)
	else begin
		failCount++;
		$error("iaddr is not zero in the first cycle after reset");
	end

	assert property (pcStep)
	else begin
		failCount++;
		$error("iaddr did not advance by 4");
	end

	assert property (noStoreInReset)
	else begin
		failCount++;
		$error("memWrite high during reset");
	end

	assert property (storeStrobeKnown)
	else begin
		failCount++;
		$error("memWrite is unknown");
	end

	assert property (storeAddrKnown)
	else begin
		failCount++;
		$error("daddr has unknown bits during a store");
	end

endmodule

`default_nettype wire

/* testbench/legCpuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module legCpuTb;
	import legPkg::*;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	localparam int driveDelay = 2;
	localparam int progDepth = 256;
	localparam logic [63:0] checkAddr = 64'h100;
	localparam string dataFile = "testbench/legCpu_testdata.txt";

	logic clk;
	logic reset;
	logic [instrWidth-1:0] instr;
	logic [63:0] iaddr;
	logic [63:0] daddr;
	logic [63:0] writeData;
	logic memWrite;
	logic [63:0] readData;

	logic [instrWidth-1:0] progMem [0:progDepth-1];
	logic [63:0] dataMem [logic [63:0]];
	string expName [$];
	logic [63:0] expAddr [$];
	logic [63:0] expValue [$];
	int progWords = 0;
	bit loaded = 1'b0;

	legCpu #(.dataWidth(64)) dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.iaddr(iaddr),
		.daddr(daddr),
		.writeData(writeData),
		.memWrite(memWrite),
		.readData(readData)
	);

	bind legCpu legCpuProps props (
		.clk(clk),
		.reset(reset),
		.iaddr(iaddr),
		.memWrite(memWrite),
		.daddr(daddr)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clkPeriod / 2) clk = ~clk;
		end
	end

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run aborted");
	endtask

	task automatic loadTestData();
		int fd;
		int count;
		int index;
		int regNum;
		int checkStart;
		string line;
		string tag;
		string name;
		logic [63:0] addr;
		logic [63:0] value;
		string regNames [$];
		int regNums [$];
		logic [63:0] regValues [$];
		for (int i = 0; i < progDepth; i++) begin
			progMem[i] = '0;
		end
		fd = $fopen(dataFile, "r");
		if (fd == 0) begin
			stopWithFailure("Cannot open the test data file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			count = $sscanf(line, "%s", tag);
			if (count < 1 || tag.substr(0, 0) == "#") begin
				continue;
			end
			case (tag)
				"P": begin
					count = $sscanf(line, "%s %h %h", tag, index, value);
					if (count != 3 || index < 0 || index >= progDepth) begin
						stopWithFailure("Malformed program record in the test data file");
					end else begin
						progMem[index] = value[instrWidth-1:0];
						if (index + 1 > progWords) begin
							progWords = index + 1;
						end
					end
				end
				"M": begin
					count = $sscanf(line, "%s %h %h", tag, addr, value);
					dataMem[addr] = value;
				end
				"S": begin
					count = $sscanf(line, "%s %s %h %h", tag, name, addr, value);
					expName.push_back(name);
					expAddr.push_back(addr);
					expValue.push_back(value);
				end
				"R": begin
					count = $sscanf(line, "%s %s %d %h", tag, name, regNum, value);
					regNames.push_back(name);
					regNums.push_back(regNum);
					regValues.push_back(value);
				end
				default: begin
					stopWithFailure("Unknown record tag in the test data file");
				end
			endcase
		end
		$fclose(fd);
		// Register checks become stores to one address, after a three-NOP gap
		checkStart = progWords + 3;
		for (int k = 0; k < regNums.size(); k++) begin
			progMem[checkStart + k] = {opStur, checkAddr[8:0], 2'b00, zeroReg,
				5'(regNums[k])};
			expName.push_back(regNames[k]);
			expAddr.push_back(checkAddr);
			expValue.push_back(regValues[k]);
		end
		progWords = checkStart + regNums.size();
	endtask

	function automatic logic [instrWidth-1:0] fetchWord(input logic [63:0] addr);
		if ($isunknown(addr) || addr[63:2] >= progDepth) begin
			return '0;
		end
		return progMem[int'(addr[63:2])];
	endfunction

	function automatic logic [63:0] loadWord(input logic [63:0] addr);
		if ($isunknown(addr)) begin
			return '0;
		end
		// Unwritten locations read back the inverted address
		if (!dataMem.exists(addr)) begin
			return ~addr;
		end
		return dataMem[addr];
	endfunction

	task automatic checkStore(input logic [63:0] addr, input logic [63:0] value);
		string name;
		logic [63:0] wantAddr;
		logic [63:0] wantValue;
		if (expName.size() == 0) begin
			stopWithFailure($sformatf("Unexpected store of %h to address %h", value, addr));
		end else begin
			name = expName.pop_front();
			wantAddr = expAddr.pop_front();
			wantValue = expValue.pop_front();
			assert (addr === wantAddr)
			else stopWithFailure($sformatf("[ERROR] %s address: expected %h, actual %h",
				name, wantAddr, addr));
			assert (value === wantValue)
			else stopWithFailure($sformatf("[ERROR] %s: expected %h, actual %h",
				name, wantValue, value));
		end
	endtask

	// Memories answer shortly after each rising edge
	always @(posedge clk) begin
		#driveDelay;
		instr = fetchWord(iaddr);
		readData = loadWord(daddr);
	end

	// Mid-cycle sampling of the store bus
	always @(negedge clk) begin
		assert (dut.props.failCount == 0)
		else stopWithFailure("A bound property on the CPU failed");
		if (!reset && memWrite === 1'b1) begin
			checkStore(daddr, writeData);
			dataMem[daddr] = writeData;
		end
	end

	initial begin
		wait (loaded);
		#((progWords + 20) * clkPeriod);
		stopWithFailure("Timeout: the program did not finish in time");
	end

	initial begin
		reset = 1'b0;
		instr = '0;
		readData = '0;
		loadTestData();
		loaded = 1'b1;
		#1;
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		reset = 1'b0;
		// Last store leaves the memory stage three words after its fetch
		wait (iaddr[63:2] >= progWords + 5);
		@(negedge clk);
		if (expName.size() != 0) begin
			stopWithFailure($sformatf("%0d expected stores never happened", expName.size()));
		end else if (dut.props.failCount != 0) begin
			stopWithFailure("A bound property on the CPU failed");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* legCpu.f */
src/legPkg.sv
src/fetchUnit.sv
src/instrDecoder.sv
src/registerFile.sv
src/executeUnit.sv
src/legCpu.sv
testbench/legCpu_props.sv
testbench/legCpuTb.sv

/* testbench/legCpu_testdata.txt */
# Tags: P index word | M address value | S name address value | R name register value
# All numbers are hex except the register number of an R record, which is decimal
P 00 CA824681
P 01 CAB579A2
P 02 CAC01FE3
P 03 CAF00024
P 07 28020025
P 08 29220026
P 09 28030087
P 0D 284500C8
P 0E 290700A9
P 0F 288500CA
P 10 28A500EB
P 11 883FFCAC
P 12 89FFFC2D
P 13 88BFFCCE
P 14 89BFFCEF
P 15 892AF0D0
P 16 896003F1
P 17 28C00032
P 18 28C00433
P 19 28E00095
P 1A 28E00496
P 1B 28E0FC97
P 1C D01F4038
P 1D 8800143F
P 21 28C0FD74
P 22 D02100B8
P 23 290103F9
M 0000000000001428 0123456789ABCDEF
S copyLdurStur 00000000ABCD1244 0123456789ABCDEF
R movzHw0 1 0000000000001234
R movzHw1 2 00000000ABCD0000
R movzHw2 3 000000FF00000000
R movzHw3 4 8001000000000000
R add 5 00000000ABCD1234
R sub 6 FFFFFFFF54331234
R addUpper 7 800100FF00000000
R and 8 0000000000011234
R orr 9 800100FFABCD1234
R eor 10 FFFFFFFFFFFE0000
R enor 11 7FFEFF005432EDCB
R addi 12 00000000ABCD2233
R subi 13 0000000000000235
R andi 14 0000000000000234
R orri 15 800100FF00000FFF
R eori 16 FFFFFFFF54331888
R enoriZeroExt 17 FFFFFFFFFFFFF7FF
R lsl0 18 0000000000001234
R lsl1 19 0000000000002468
R lsl63 20 8000000000000000
R lsr0 21 8001000000000000
R lsr1 22 4000800000000000
R lsr63 23 0000000000000001
R ldur 24 0123456789ABCDEF
R readZeroReg 25 0000000000001234
R nopUntouched 26 0000000000000000
R zeroRegWrite 31 0000000000000000
